//--- bench/tb_cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_top;

    localparam int IMEM_WORDS = 512;
    localparam int DMEM_WORDS = 1024;
    localparam int RAND_LEN   = 200;

    logic                clk;
    logic                arst_n = 1'b0;
    logic                inst_sram_en;
    cpu_pkg::word_t      inst_sram_addr;
    cpu_pkg::word_t      inst_sram_rdata = '0;
    logic                data_sram_en;
    logic [3:0]          data_sram_we;
    cpu_pkg::word_t      data_sram_addr;
    cpu_pkg::word_t      data_sram_wdata;
    cpu_pkg::word_t      data_sram_rdata = '0;
    cpu_pkg::word_t      debug_wb_pc;
    logic [3:0]          debug_wb_rf_we;
    cpu_pkg::reg_idx_t   debug_wb_rf_wnum;
    cpu_pkg::word_t      debug_wb_rf_wdata;

    cpu_pkg::word_t      imem [IMEM_WORDS];
    cpu_pkg::word_t      dmem [DMEM_WORDS];
    cpu_pkg::word_t      model_dmem [DMEM_WORDS];
    cpu_pkg::word_t      model_regs [cpu_pkg::REG_COUNT];
    cpu_pkg::word_t      prog [$];
    cpu_pkg::word_t      exp_pc [$];
    cpu_pkg::reg_idx_t   exp_rd [$];
    cpu_pkg::word_t      exp_data [$];
    int                  errors = 0;
    int                  tests_run = 0;
    int                  tests_failed = 0;
    int                  cycles = 0;
    int                  cycle_limit = 1000;

    cpu_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // both memories answer one cycle after the address
    always @(posedge clk) begin
        if (inst_sram_en) inst_sram_rdata <= imem[inst_sram_addr[10:2]];
    end

    always @(posedge clk) begin
        if (data_sram_en) begin
            data_sram_rdata <= dmem[data_sram_addr[11:2]];
            if (data_sram_we == 4'hf) dmem[data_sram_addr[11:2]] <= data_sram_wdata;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: the program did not finish within %0d cycles", cycle_limit);
            $display("Result: FAILED");
            $finish;
        end
    end

    // every register write must match the next reference entry
    always @(negedge clk) begin
        if (arst_n && debug_wb_rf_we != 4'h0) begin
            if (exp_pc.size() == 0) begin
                $display("unexpected register write at %0t: r%0d from pc %h",
                         $time, debug_wb_rf_wnum, debug_wb_pc);
                errors++;
            end else begin
                assert (debug_wb_rf_we == 4'hf && debug_wb_pc == exp_pc[0] &&
                        debug_wb_rf_wnum == exp_rd[0] && debug_wb_rf_wdata == exp_data[0])
                else begin
                    $display("FAIL %0t: trace pc %h r%0d %h, expected pc %h r%0d %h", $time,
                             debug_wb_pc, debug_wb_rf_wnum, debug_wb_rf_wdata,
                             exp_pc[0], exp_rd[0], exp_data[0]);
                    errors++;
                end
                void'(exp_pc.pop_front());
                void'(exp_rd.pop_front());
                void'(exp_data.pop_front());
            end
        end
    end

    function automatic cpu_pkg::word_t enc_r3(input logic [16:0] op, input cpu_pkg::reg_idx_t rd,
                                              input cpu_pkg::reg_idx_t rj,
                                              input cpu_pkg::reg_idx_t rk);
        return {op, rk, rj, rd};
    endfunction

    function automatic cpu_pkg::word_t enc_ri12(input logic [9:0] op, input cpu_pkg::reg_idx_t rd,
                                                input cpu_pkg::reg_idx_t rj,
                                                input logic [11:0] imm);
        return {op, imm, rj, rd};
    endfunction

    function automatic cpu_pkg::word_t enc_lu12i(input cpu_pkg::reg_idx_t rd,
                                                 input logic [19:0] imm);
        return {cpu_pkg::OP_LU12I_W, imm, rd};
    endfunction

    // offsets are counted in words
    function automatic cpu_pkg::word_t enc_br(input logic [5:0] op, input cpu_pkg::reg_idx_t rj,
                                              input cpu_pkg::reg_idx_t rd,
                                              input logic [15:0] offs);
        return {op, offs, rj, rd};
    endfunction

    function automatic cpu_pkg::word_t enc_jump(input logic [25:0] offs);
        return {cpu_pkg::OP_B, offs[15:0], offs[25:16]};
    endfunction

    function automatic cpu_pkg::reg_idx_t pick_reg();
        return cpu_pkg::reg_idx_t'($urandom_range(31, 0));
    endfunction

    // architectural model, stops at the self branch that parks the core
    task automatic run_model();
        cpu_pkg::word_t    pc;
        cpu_pkg::word_t    next;
        cpu_pkg::word_t    inst;
        cpu_pkg::word_t    a;
        cpu_pkg::word_t    b;
        cpu_pkg::word_t    d;
        cpu_pkg::word_t    si12;
        cpu_pkg::word_t    addr;
        cpu_pkg::word_t    res;
        cpu_pkg::reg_idx_t rd;
        logic              wr;
        int                steps;
        pc    = cpu_pkg::RESET_PC;
        inst  = imem[pc[10:2]];
        steps = 0;
        while (inst != enc_jump(26'd0) && steps < 4000) begin
            wr   = 1'b0;
            res  = '0;
            next = pc + 32'd4;
            rd   = inst[4:0];
            a    = model_regs[inst[9:5]];
            b    = model_regs[inst[14:10]];
            d    = model_regs[rd];
            si12 = 32'($signed(inst[21:10]));
            addr = a + si12;
            if (inst[31:15] == cpu_pkg::OP_ADD_W) begin
                res = a + b;
                wr  = 1'b1;
            end else if (inst[31:15] == cpu_pkg::OP_SUB_W) begin
                res = a - b;
                wr  = 1'b1;
            end else if (inst[31:15] == cpu_pkg::OP_AND) begin
                res = a & b;
                wr  = 1'b1;
            end else if (inst[31:15] == cpu_pkg::OP_OR) begin
                res = a | b;
                wr  = 1'b1;
            end else if (inst[31:15] == cpu_pkg::OP_XOR) begin
                res = a ^ b;
                wr  = 1'b1;
            end else if (inst[31:22] == cpu_pkg::OP_ADDI_W) begin
                res = addr;
                wr  = 1'b1;
            end else if (inst[31:22] == cpu_pkg::OP_LD_W) begin
                res = model_dmem[addr[11:2]];
                wr  = 1'b1;
            end else if (inst[31:22] == cpu_pkg::OP_ST_W) begin
                model_dmem[addr[11:2]] = d;
            end else if (inst[31:25] == cpu_pkg::OP_LU12I_W) begin
                res = 32'(inst[24:5]) << 12;
                wr  = 1'b1;
            end else if ((inst[31:26] == cpu_pkg::OP_BEQ && a == d) ||
                         (inst[31:26] == cpu_pkg::OP_BNE && a != d)) begin
                next = pc + 32'($signed(inst[25:10])) * 4;
            end else if (inst[31:26] == cpu_pkg::OP_B) begin
                next = pc + 32'($signed({inst[9:0], inst[25:10]})) * 4;
            end
            if (wr && rd != 5'd0) begin
                model_regs[rd] = res;
                exp_pc.push_back(pc);
                exp_rd.push_back(rd);
                exp_data.push_back(res);
            end
            pc   = next;
            inst = imem[pc[10:2]];
            steps++;
        end
    endtask

    task automatic run_test(input string name);
        int             err_start;
        cpu_pkg::word_t park_pc;
        err_start = errors;
        @(negedge clk);
        arst_n = 1'b0; // core held while its memories are reloaded
        prog.push_back(enc_jump(26'd0));
        for (int i = 0; i < IMEM_WORDS; i++) imem[i] = cpu_pkg::NOP_INST;
        foreach (prog[i]) imem[i] = prog[i];
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i]       = (cpu_pkg::word_t'(i) * 32'h9e37_79b9) ^ 32'h5a5a_0000;
            model_dmem[i] = dmem[i];
        end
        exp_pc.delete();
        exp_rd.delete();
        exp_data.delete();
        run_model();
        park_pc     = cpu_pkg::RESET_PC + 32'(4 * (prog.size() - 1));
        cycles      = 0;
        cycle_limit = 4 * prog.size() + 100;
        repeat (2) @(negedge clk);
        assert (debug_wb_rf_we == 4'h0 && data_sram_we == 4'h0 &&
                inst_sram_addr == cpu_pkg::RESET_PC)
        else begin
            $display("FAIL %0t: reset state we %h dwe %h addr %h", $time,
                     debug_wb_rf_we, data_sram_we, inst_sram_addr);
            errors++;
        end
        arst_n = 1'b1;
        // the parking branch is fetched once everything before it has issued
        while (inst_sram_addr != park_pc) @(negedge clk);
        repeat (12) @(negedge clk); // drain the pipe, catch extra writes
        if (exp_pc.size() != 0) begin
            $display("%0d expected register writes never appeared", exp_pc.size());
            errors++;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            assert (dmem[i] == model_dmem[i])
            else begin
                $display("FAIL %0t: data word %0d is %h, expected %h", $time, i,
                         dmem[i], model_dmem[i]);
                errors++;
            end
        end
        tests_run++;
        if (errors != err_start) tests_failed++;
        $display("test %s: %s", name, (errors == err_start) ? "ok" : "errors");
        prog.delete();
    endtask

    task automatic build_random();
        int kind;
        int off;
        int room;
        for (int i = 1; i < 32; i++) begin
            prog.push_back(enc_ri12(cpu_pkg::OP_ADDI_W, cpu_pkg::reg_idx_t'(i), 5'd0,
                                    12'($urandom)));
        end
        for (int i = 0; i < RAND_LEN; i++) begin
            kind = $urandom_range(9, 0);
            room = 31 + RAND_LEN - prog.size(); // forward branches stay inside the program
            off  = $urandom_range(4, 1);
            if (off > room) off = room;
            case (kind)
                0: prog.push_back(enc_r3(cpu_pkg::OP_ADD_W, pick_reg(), pick_reg(), pick_reg()));
                1: prog.push_back(enc_r3(cpu_pkg::OP_SUB_W, pick_reg(), pick_reg(), pick_reg()));
                2: prog.push_back(enc_r3(cpu_pkg::OP_AND, pick_reg(), pick_reg(), pick_reg()));
                3: prog.push_back(enc_r3(cpu_pkg::OP_OR, pick_reg(), pick_reg(), pick_reg()));
                4: prog.push_back(enc_r3(cpu_pkg::OP_XOR, pick_reg(), pick_reg(), pick_reg()));
                5: prog.push_back(enc_ri12(cpu_pkg::OP_ADDI_W, pick_reg(), pick_reg(),
                                           12'($urandom)));
                6: prog.push_back(enc_lu12i(pick_reg(), 20'($urandom)));
                7: prog.push_back(enc_br(cpu_pkg::OP_BEQ, pick_reg(), pick_reg(), 16'(off)));
                8: prog.push_back(enc_br(cpu_pkg::OP_BNE, pick_reg(), pick_reg(), 16'(off)));
                default: prog.push_back(enc_jump(26'(off)));
            endcase
        end
    endtask

    initial begin
        void'($urandom(32'hd1c9_2697));
        for (int i = 0; i < cpu_pkg::REG_COUNT; i++) model_regs[i] = '0;

        run_test("reset");

        prog.push_back(enc_ri12(cpu_pkg::OP_ADDI_W, 5'd1, 5'd0, 12'h123));
        prog.push_back(enc_ri12(cpu_pkg::OP_ADDI_W, 5'd2, 5'd0, 12'hffb));
        prog.push_back(enc_lu12i(5'd3, 20'habcde));
        prog.push_back(enc_r3(cpu_pkg::OP_ADD_W, 5'd4, 5'd1, 5'd2));
        prog.push_back(enc_r3(cpu_pkg::OP_SUB_W, 5'd5, 5'd1, 5'd2));
        prog.push_back(enc_r3(cpu_pkg::OP_AND, 5'd6, 5'd3, 5'd2));
        prog.push_back(enc_r3(cpu_pkg::OP_OR, 5'd7, 5'd3, 5'd1));
        prog.push_back(enc_r3(cpu_pkg::OP_XOR, 5'd8, 5'd3, 5'd2));
        prog.push_back(enc_ri12(cpu_pkg::OP_ADDI_W, 5'd9, 5'd3, 12'h7ff));
        prog.push_back(enc_lu12i(5'd10, 20'h80000));
        prog.push_back(enc_ri12(cpu_pkg::OP_ADDI_W, 5'd0, 5'd1, 12'h001)); // r0 write, no trace
        run_test("alu");

        prog.push_back(enc_ri12(cpu_pkg::OP_ADDI_W, 5'd1, 5'd0, 12'h001));
        prog.push_back(enc_r3(cpu_pkg::OP_ADD_W, 5'd2, 5'd1, 5'd1));
        prog.push_back(enc_r3(cpu_pkg::OP_ADD_W, 5'd3, 5'd2, 5'd1));
        prog.push_back(enc_r3(cpu_pkg::OP_SUB_W, 5'd4, 5'd3, 5'd2));
        prog.push_back(enc_r3(cpu_pkg::OP_XOR, 5'd5, 5'd4, 5'd3));
        prog.push_back(enc_ri12(cpu_pkg::OP_ADDI_W, 5'd5, 5'd5, 12'h007));
        prog.push_back(enc_r3(cpu_pkg::OP_OR, 5'd6, 5'd5, 5'd4));
        prog.push_back(enc_r3(cpu_pkg::OP_AND, 5'd7, 5'd6, 5'd6));
        prog.push_back(enc_r3(cpu_pkg::OP_ADD_W, 5'd7, 5'd7, 5'd7));
        run_test("dependent chain");

        prog.push_back(enc_ri12(cpu_pkg::OP_ADDI_W, 5'd1, 5'd0, 12'h100));
        prog.push_back(enc_lu12i(5'd2, 20'h12345));
        prog.push_back(enc_ri12(cpu_pkg::OP_ADDI_W, 5'd2, 5'd2, 12'h678));
        prog.push_back(enc_ri12(cpu_pkg::OP_ST_W, 5'd2, 5'd1, 12'h000));
        prog.push_back(enc_ri12(cpu_pkg::OP_LD_W, 5'd3, 5'd1, 12'h000)); // same address
        prog.push_back(enc_ri12(cpu_pkg::OP_ADDI_W, 5'd4, 5'd0, 12'hfff));
        prog.push_back(enc_ri12(cpu_pkg::OP_ST_W, 5'd4, 5'd1, 12'h008));
        prog.push_back(enc_ri12(cpu_pkg::OP_ST_W, 5'd2, 5'd1, 12'hffc));
        prog.push_back(enc_ri12(cpu_pkg::OP_LD_W, 5'd5, 5'd1, 12'h008));
        prog.push_back(enc_ri12(cpu_pkg::OP_LD_W, 5'd6, 5'd1, 12'h004)); // untouched word
        prog.push_back(enc_r3(cpu_pkg::OP_ADD_W, 5'd7, 5'd3, 5'd5));
        prog.push_back(enc_ri12(cpu_pkg::OP_LD_W, 5'd8, 5'd1, 12'hffc));
        run_test("load store");

        prog.push_back(enc_ri12(cpu_pkg::OP_ADDI_W, 5'd1, 5'd0, 12'h005));
        prog.push_back(enc_ri12(cpu_pkg::OP_ADDI_W, 5'd2, 5'd0, 12'h005));
        prog.push_back(enc_ri12(cpu_pkg::OP_ADDI_W, 5'd3, 5'd0, 12'h007));
        prog.push_back(enc_br(cpu_pkg::OP_BEQ, 5'd1, 5'd2, 16'd2)); // taken
        prog.push_back(enc_ri12(cpu_pkg::OP_ADDI_W, 5'd4, 5'd0, 12'h001));
        prog.push_back(enc_br(cpu_pkg::OP_BNE, 5'd1, 5'd2, 16'd2)); // not taken
        prog.push_back(enc_ri12(cpu_pkg::OP_ADDI_W, 5'd5, 5'd0, 12'h002));
        prog.push_back(enc_br(cpu_pkg::OP_BEQ, 5'd1, 5'd3, 16'd2)); // not taken
        prog.push_back(enc_ri12(cpu_pkg::OP_ADDI_W, 5'd6, 5'd0, 12'h003));
        prog.push_back(enc_br(cpu_pkg::OP_BNE, 5'd1, 5'd3, 16'd3)); // taken
        prog.push_back(enc_ri12(cpu_pkg::OP_ADDI_W, 5'd7, 5'd0, 12'h004));
        prog.push_back(enc_ri12(cpu_pkg::OP_ADDI_W, 5'd8, 5'd0, 12'h005));
        prog.push_back(enc_jump(26'd2));
        prog.push_back(enc_ri12(cpu_pkg::OP_ADDI_W, 5'd9, 5'd0, 12'h006));
        prog.push_back(enc_ri12(cpu_pkg::OP_ADDI_W, 5'd10, 5'd0, 12'h009));
        run_test("branch");

        build_random();
        run_test("random");

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
hw/cpu_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/mem_wb_stage.sv
hw/reg_file.sv
hw/hazard_ctrl.sv
hw/cpu_top.sv
bench/tb_cpu_top.sv

//--- hw/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;    // data, address or instruction word
    typedef logic [4:0]  reg_idx_t; // architectural register number

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B // lu12i.w result is the immediate itself
    } alu_op_e;

    localparam int    REG_COUNT = 32;
    localparam word_t RESET_PC  = 32'h1c00_0000;
    localparam word_t NOP_INST  = 32'h0280_0000; // addi.w r0,r0,0

    // three-register forms, inst[31:15]
    localparam logic [16:0] OP_ADD_W = 17'h00020;
    localparam logic [16:0] OP_SUB_W = 17'h00022;
    localparam logic [16:0] OP_AND   = 17'h00029;
    localparam logic [16:0] OP_OR    = 17'h0002a;
    localparam logic [16:0] OP_XOR   = 17'h0002b;

    // 12-bit immediate forms, inst[31:22]
    localparam logic [9:0] OP_ADDI_W = 10'h00a;
    localparam logic [9:0] OP_LD_W   = 10'h0a2;
    localparam logic [9:0] OP_ST_W   = 10'h0a6;

    // 20-bit immediate form, inst[31:25]
    localparam logic [6:0] OP_LU12I_W = 7'h0a;

    // branches, inst[31:26]
    localparam logic [5:0] OP_B   = 6'h14;
    localparam logic [5:0] OP_BEQ = 6'h16;
    localparam logic [5:0] OP_BNE = 6'h17;

endpackage

`default_nettype wire

//--- hw/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
    input  logic              clk,
    input  logic              arst_n,
    // instruction SRAM
    output logic              inst_sram_en,
    output cpu_pkg::word_t    inst_sram_addr,
    input  cpu_pkg::word_t    inst_sram_rdata,
    // data SRAM
    output logic              data_sram_en,
    output logic [3:0]        data_sram_we,
    output cpu_pkg::word_t    data_sram_addr,
    output cpu_pkg::word_t    data_sram_wdata,
    input  cpu_pkg::word_t    data_sram_rdata,
    // writeback trace
    output cpu_pkg::word_t    debug_wb_pc,
    output logic [3:0]        debug_wb_rf_we,
    output cpu_pkg::reg_idx_t debug_wb_rf_wnum,
    output cpu_pkg::word_t    debug_wb_rf_wdata
);

    logic              stall, bubble, br_taken;
    cpu_pkg::word_t    br_target, if_pc, if_inst;
    cpu_pkg::reg_idx_t rs1, rs2;
    logic              rs1_used, rs2_used;
    cpu_pkg::word_t    rf_rdata1, rf_rdata2;
    cpu_pkg::word_t    ex_pc, ex_src1, ex_src2, ex_imm, ex_store_data;
    logic              ex_imm_sel, ex_rf_we, ex_mem_re, ex_mem_we;
    cpu_pkg::alu_op_e  ex_alu_op;
    cpu_pkg::reg_idx_t ex_rd, mem_rd, wb_rd;
    cpu_pkg::word_t    mem_pc, mem_alu_result, mem_store_data;
    logic              mem_rf_we, mem_re, mem_we, wb_rf_we;
    cpu_pkg::word_t    wb_wdata, wb_pc;

    fetch_stage u_fetch (
        .clk, .arst_n, .stall, .br_taken, .br_target,
        .inst_sram_en, .inst_sram_addr, .inst_sram_rdata,
        .if_pc, .if_inst
    );

    decode_stage u_decode (
        .clk, .arst_n, .if_pc, .if_inst, .stall, .bubble,
        .rs1, .rs2, .rs1_used, .rs2_used, .rf_rdata1, .rf_rdata2,
        .br_taken, .br_target,
        .ex_pc, .ex_src1, .ex_src2, .ex_imm, .ex_store_data,
        .ex_imm_sel, .ex_rf_we, .ex_mem_re, .ex_mem_we, .ex_alu_op, .ex_rd
    );

    execute_stage u_execute (
        .clk, .arst_n,
        .ex_pc, .ex_src1, .ex_src2, .ex_imm, .ex_store_data,
        .ex_imm_sel, .ex_rf_we, .ex_mem_re, .ex_mem_we, .ex_alu_op, .ex_rd,
        .mem_pc, .mem_alu_result, .mem_store_data, .mem_rf_we, .mem_re, .mem_we, .mem_rd
    );

    mem_wb_stage u_mem_wb (
        .clk, .arst_n,
        .mem_pc, .mem_alu_result, .mem_store_data, .mem_rf_we, .mem_re, .mem_we, .mem_rd,
        .data_sram_en, .data_sram_we, .data_sram_addr, .data_sram_wdata, .data_sram_rdata,
        .wb_rf_we, .wb_rd, .wb_wdata, .wb_pc
    );

    reg_file u_rf (
        .clk,
        .raddr1 (rs1),
        .raddr2 (rs2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (wb_rf_we),
        .waddr  (wb_rd),
        .wdata  (wb_wdata)
    );

    hazard_ctrl u_hazard (
        .rs1, .rs2, .rs1_used, .rs2_used,
        .ex_rd, .mem_rd, .wb_rd, .ex_rf_we, .mem_rf_we, .wb_rf_we,
        .stall, .bubble
    );

    // trace mirrors the register file write port
    assign debug_wb_pc       = wb_pc;
    assign debug_wb_rf_we    = {4{wb_rf_we}};
    assign debug_wb_rf_wnum  = wb_rd;
    assign debug_wb_rf_wdata = wb_wdata;

endmodule

`default_nettype wire

//--- hw/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic               clk,
    input  logic               arst_n,
    input  cpu_pkg::word_t     if_pc,
    input  cpu_pkg::word_t     if_inst,
    input  logic               stall,
    input  logic               bubble,
    output cpu_pkg::reg_idx_t  rs1,
    output cpu_pkg::reg_idx_t  rs2,
    output logic               rs1_used,
    output logic               rs2_used,
    input  cpu_pkg::word_t     rf_rdata1,
    input  cpu_pkg::word_t     rf_rdata2,
    output logic               br_taken,
    output cpu_pkg::word_t     br_target,
    output cpu_pkg::word_t     ex_pc,
    output cpu_pkg::word_t     ex_src1,
    output cpu_pkg::word_t     ex_src2,
    output cpu_pkg::word_t     ex_imm,
    output cpu_pkg::word_t     ex_store_data,
    output logic               ex_imm_sel,
    output logic               ex_rf_we,
    output logic               ex_mem_re,
    output logic               ex_mem_we,
    output cpu_pkg::alu_op_e   ex_alu_op,
    output cpu_pkg::reg_idx_t  ex_rd
);

    logic is_add, is_sub, is_and, is_or, is_xor;
    logic is_addi, is_lu12i, is_ld, is_st;
    logic is_beq, is_bne, is_b;
    logic is_alu3r;
    logic rf_we, operands_eq;
    cpu_pkg::reg_idx_t rd;
    cpu_pkg::word_t    imm, offs16, offs26;
    cpu_pkg::alu_op_e  alu_op;

    assign is_add   = if_inst[31:15] == cpu_pkg::OP_ADD_W;
    assign is_sub   = if_inst[31:15] == cpu_pkg::OP_SUB_W;
    assign is_and   = if_inst[31:15] == cpu_pkg::OP_AND;
    assign is_or    = if_inst[31:15] == cpu_pkg::OP_OR;
    assign is_xor   = if_inst[31:15] == cpu_pkg::OP_XOR;
    assign is_addi  = if_inst[31:22] == cpu_pkg::OP_ADDI_W;
    assign is_ld    = if_inst[31:22] == cpu_pkg::OP_LD_W;
    assign is_st    = if_inst[31:22] == cpu_pkg::OP_ST_W;
    assign is_lu12i = if_inst[31:25] == cpu_pkg::OP_LU12I_W;
    assign is_beq   = if_inst[31:26] == cpu_pkg::OP_BEQ;
    assign is_bne   = if_inst[31:26] == cpu_pkg::OP_BNE;
    assign is_b     = if_inst[31:26] == cpu_pkg::OP_B;
    assign is_alu3r = is_add | is_sub | is_and | is_or | is_xor;

    assign rd  = if_inst[4:0];
    assign rs1 = if_inst[9:5];
    // st.w, beq and bne read rd as their second source
    assign rs2 = (is_st || is_beq || is_bne) ? rd : if_inst[14:10];

    assign rs1_used = is_alu3r | is_addi | is_ld | is_st | is_beq | is_bne;
    assign rs2_used = is_alu3r | is_st | is_beq | is_bne;

    assign rf_we = (is_alu3r | is_addi | is_lu12i | is_ld) && (rd != '0); // r0 stays zero

    assign imm    = is_lu12i ? {if_inst[24:5], 12'b0} : {{20{if_inst[21]}}, if_inst[21:10]};
    assign offs16 = {{14{if_inst[25]}}, if_inst[25:10], 2'b00};
    assign offs26 = {{4{if_inst[9]}}, if_inst[9:0], if_inst[25:10], 2'b00};

    always_comb begin
        if (is_sub) begin
            alu_op = cpu_pkg::ALU_SUB;
        end else if (is_and) begin
            alu_op = cpu_pkg::ALU_AND;
        end else if (is_or) begin
            alu_op = cpu_pkg::ALU_OR;
        end else if (is_xor) begin
            alu_op = cpu_pkg::ALU_XOR;
        end else if (is_lu12i) begin
            alu_op = cpu_pkg::ALU_PASS_B;
        end else begin
            alu_op = cpu_pkg::ALU_ADD; // add.w, addi.w and address add
        end
    end

    // branch resolve, only trusted when the operands are not stale
    assign operands_eq = rf_rdata1 == rf_rdata2;
    assign br_taken    = !stall && (is_b || (is_beq && operands_eq) || (is_bne && !operands_eq));
    assign br_target   = if_pc + (is_b ? offs26 : offs16);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_rf_we  <= 1'b0;
            ex_mem_re <= 1'b0;
            ex_mem_we <= 1'b0;
        end else if (bubble) begin
            ex_rf_we  <= 1'b0;
            ex_mem_re <= 1'b0;
            ex_mem_we <= 1'b0;
        end else begin
            ex_rf_we  <= rf_we;
            ex_mem_re <= is_ld;
            ex_mem_we <= is_st;
        end
    end

    always_ff @(posedge clk) begin
        ex_pc         <= if_pc;
        ex_src1       <= rf_rdata1;
        ex_src2       <= rf_rdata2;
        ex_imm        <= imm;
        ex_store_data <= rf_rdata2;
        ex_imm_sel    <= is_addi | is_lu12i | is_ld | is_st;
        ex_alu_op     <= alu_op;
        ex_rd         <= rd;
    end

endmodule

`default_nettype wire

//--- hw/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic              clk,
    input  logic              arst_n,
    input  cpu_pkg::word_t    ex_pc,
    input  cpu_pkg::word_t    ex_src1,
    input  cpu_pkg::word_t    ex_src2,
    input  cpu_pkg::word_t    ex_imm,
    input  cpu_pkg::word_t    ex_store_data,
    input  logic              ex_imm_sel,
    input  logic              ex_rf_we,
    input  logic              ex_mem_re,
    input  logic              ex_mem_we,
    input  cpu_pkg::alu_op_e  ex_alu_op,
    input  cpu_pkg::reg_idx_t ex_rd,
    output cpu_pkg::word_t    mem_pc,
    output cpu_pkg::word_t    mem_alu_result,
    output cpu_pkg::word_t    mem_store_data,
    output logic              mem_rf_we,
    output logic              mem_re,
    output logic              mem_we,
    output cpu_pkg::reg_idx_t mem_rd
);

    cpu_pkg::word_t op_b;
    cpu_pkg::word_t alu_result;

    assign op_b = ex_imm_sel ? ex_imm : ex_src2;

    always_comb begin
        case (ex_alu_op)
            cpu_pkg::ALU_ADD:    alu_result = ex_src1 + op_b;
            cpu_pkg::ALU_SUB:    alu_result = ex_src1 - op_b;
            cpu_pkg::ALU_AND:    alu_result = ex_src1 & op_b;
            cpu_pkg::ALU_OR:     alu_result = ex_src1 | op_b;
            cpu_pkg::ALU_XOR:    alu_result = ex_src1 ^ op_b;
            cpu_pkg::ALU_PASS_B: alu_result = op_b;
            default:             alu_result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_rf_we <= 1'b0;
            mem_re    <= 1'b0;
            mem_we    <= 1'b0;
        end else begin
            mem_rf_we <= ex_rf_we;
            mem_re    <= ex_mem_re;
            mem_we    <= ex_mem_we;
        end
    end

    always_ff @(posedge clk) begin
        mem_pc         <= ex_pc;
        mem_alu_result <= alu_result; // also the load/store address
        mem_store_data <= ex_store_data;
        mem_rd         <= ex_rd;
    end

endmodule

`default_nettype wire

//--- hw/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           stall,
    input  logic           br_taken,
    input  cpu_pkg::word_t br_target,
    output logic           inst_sram_en,
    output cpu_pkg::word_t inst_sram_addr,
    input  cpu_pkg::word_t inst_sram_rdata,
    output cpu_pkg::word_t if_pc,
    output cpu_pkg::word_t if_inst
);

    cpu_pkg::word_t pc;        // address of the word now on inst_sram_rdata
    logic           fetch_vld; // rdata is meaningless in the first cycle out of reset

    assign inst_sram_en = 1'b1;

    // next address to the SRAM
    always_comb begin
        if (stall) begin
            inst_sram_addr = pc; // re-read so the same word comes back
        end else if (br_taken) begin
            inst_sram_addr = br_target;
        end else begin
            inst_sram_addr = pc + 32'd4;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc        <= cpu_pkg::RESET_PC - 32'd4;
            fetch_vld <= 1'b0;
            if_pc     <= '0;
            if_inst   <= cpu_pkg::NOP_INST;
        end else begin
            pc        <= inst_sram_addr;
            fetch_vld <= 1'b1;
            if (!stall) begin
                if_pc   <= pc;
                // the word behind a taken branch is dropped
                if_inst <= (br_taken || !fetch_vld) ? cpu_pkg::NOP_INST : inst_sram_rdata;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/hazard_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_ctrl (
    input  cpu_pkg::reg_idx_t rs1,
    input  cpu_pkg::reg_idx_t rs2,
    input  logic              rs1_used,
    input  logic              rs2_used,
    input  cpu_pkg::reg_idx_t ex_rd,
    input  cpu_pkg::reg_idx_t mem_rd,
    input  cpu_pkg::reg_idx_t wb_rd,
    input  logic              ex_rf_we,
    input  logic              mem_rf_we,
    input  logic              wb_rf_we,
    output logic              stall,
    output logic              bubble
);

    // one source against one in-flight producer
    function automatic logic raw_hit(input cpu_pkg::reg_idx_t src, input logic used,
                                     input cpu_pkg::reg_idx_t dst, input logic we);
        raw_hit = used && we && (dst != '0) && (src == dst);
    endfunction

    logic hit_rs1, hit_rs2;

    assign hit_rs1 = raw_hit(rs1, rs1_used, ex_rd, ex_rf_we)
                   | raw_hit(rs1, rs1_used, mem_rd, mem_rf_we)
                   | raw_hit(rs1, rs1_used, wb_rd, wb_rf_we);
    assign hit_rs2 = raw_hit(rs2, rs2_used, ex_rd, ex_rf_we)
                   | raw_hit(rs2, rs2_used, mem_rd, mem_rf_we)
                   | raw_hit(rs2, rs2_used, wb_rd, wb_rf_we);

    assign stall  = hit_rs1 | hit_rs2;
    assign bubble = stall; // decode holds, execute gets an empty slot

endmodule

`default_nettype wire

//--- hw/mem_wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_wb_stage (
    input  logic              clk,
    input  logic              arst_n,
    input  cpu_pkg::word_t    mem_pc,
    input  cpu_pkg::word_t    mem_alu_result,
    input  cpu_pkg::word_t    mem_store_data,
    input  logic              mem_rf_we,
    input  logic              mem_re,
    input  logic              mem_we,
    input  cpu_pkg::reg_idx_t mem_rd,
    output logic              data_sram_en,
    output logic [3:0]        data_sram_we,
    output cpu_pkg::word_t    data_sram_addr,
    output cpu_pkg::word_t    data_sram_wdata,
    input  cpu_pkg::word_t    data_sram_rdata,
    output logic              wb_rf_we,
    output cpu_pkg::reg_idx_t wb_rd,
    output cpu_pkg::word_t    wb_wdata,
    output cpu_pkg::word_t    wb_pc
);

    logic           wb_from_mem; // load data arrives in the writeback cycle
    cpu_pkg::word_t wb_alu_result;

    // word accesses only, so all four lanes or none
    assign data_sram_en    = mem_re | mem_we;
    assign data_sram_we    = {4{mem_we}};
    assign data_sram_addr  = mem_alu_result;
    assign data_sram_wdata = mem_store_data;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_rf_we    <= 1'b0;
            wb_from_mem <= 1'b0;
        end else begin
            wb_rf_we    <= mem_rf_we;
            wb_from_mem <= mem_re;
        end
    end

    always_ff @(posedge clk) begin
        wb_pc         <= mem_pc;
        wb_rd         <= mem_rd;
        wb_alu_result <= mem_alu_result;
    end

    assign wb_wdata = wb_from_mem ? data_sram_rdata : wb_alu_result;

endmodule

`default_nettype wire

//--- hw/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic              clk,
    input  cpu_pkg::reg_idx_t raddr1,
    input  cpu_pkg::reg_idx_t raddr2,
    output cpu_pkg::word_t    rdata1,
    output cpu_pkg::word_t    rdata2,
    input  logic              we,
    input  cpu_pkg::reg_idx_t waddr,
    input  cpu_pkg::word_t    wdata
);

    cpu_pkg::word_t regs [cpu_pkg::REG_COUNT];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // no bypass from the write port, the interlock covers writeback
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_cpu_top -Mdir obj_dir &&
out="$(./obj_dir/Vtb_cpu_top)" &&
printf '%s\n' "$out" &&
printf '%s\n' "$out" | grep -qx "Result: PASSED" ||
{ echo "simulation failed"; exit 1; }
